// ==== hdl/branch_resolve.sv ====
`timescale 1ns/1ps
`include "rv_mem_config.svh"

module branch_resolve (
    input  rv_mem_pkg::branch_kind_e branch_kind,
    input  logic [`RV_XLEN-1:0]      rs1_val,
    input  logic [`RV_XLEN-1:0]      rs2_val,
    input  logic [`RV_XLEN-1:0]      alu_result,
    input  logic [`RV_XLEN-1:0]      branch_target,
    output logic                     redirect,
    output logic [`RV_XLEN-1:0]      redirect_pc
);

    logic is_eq;
    logic is_lt;
    logic is_ltu;

    // GE and GEU are the complements of these three
    assign is_eq  = (rs1_val == rs2_val);
    assign is_lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign is_ltu = (rs1_val < rs2_val);

    always_comb begin
        case (branch_kind)
            rv_mem_pkg::br_eq:   redirect = is_eq;
            rv_mem_pkg::br_ne:   redirect = !is_eq;
            rv_mem_pkg::br_lt:   redirect = is_lt;
            rv_mem_pkg::br_ge:   redirect = !is_lt;
            rv_mem_pkg::br_ltu:  redirect = is_ltu;
            rv_mem_pkg::br_geu:  redirect = !is_ltu;
            rv_mem_pkg::br_jalr: redirect = 1'b1;   // Unconditional
            default:             redirect = 1'b0;
        endcase
    end

    // JALR target is rs1 + imm, already formed by the ALU
    assign redirect_pc = (branch_kind == rv_mem_pkg::br_jalr) ? alu_result : branch_target;

endmodule

// ==== hdl/mem_access_stage.sv ====
`timescale 1ns/1ps
`include "rv_mem_config.svh"

module mem_access_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  keep,
    input  logic                  nop,
    input  rv_mem_pkg::ex_mem_t   ex_in,

    output rv_mem_pkg::dmem_req_t dmem,
    input  logic [`RV_XLEN-1:0]   rdata,    // Same-cycle read data

    output logic [`RV_XLEN-1:0]   redirect_pc,
    output logic                  redirect,

    output rv_mem_pkg::mem_wb_t   wb
);

    rv_mem_pkg::mem_ctrl_t ctrl;   // Decoded kinds and rd

    mem_op_decode u_decode (
        .ex_in (ex_in),
        .ctrl  (ctrl),
        .dmem  (dmem)
    );

    branch_resolve u_branch (
        .branch_kind   (ctrl.branch_kind),
        .rs1_val       (ex_in.rs1_val),
        .rs2_val       (ex_in.rs2_val),
        .alu_result    (ex_in.alu_result),
        .branch_target (ex_in.branch_target),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

    // Registered side lags the request by one edge
    mem_wb_reg u_wb_reg (
        .clk   (clk),
        .rst   (rst),
        .keep  (keep),
        .nop   (nop),
        .ex_in (ex_in),
        .ctrl  (ctrl),
        .rdata (rdata),
        .wb    (wb)
    );

endmodule

// ==== hdl/mem_op_decode.sv ====
`timescale 1ns/1ps
`include "rv_mem_config.svh"

module mem_op_decode (
    input  rv_mem_pkg::ex_mem_t   ex_in,
    output rv_mem_pkg::mem_ctrl_t ctrl,
    output rv_mem_pkg::dmem_req_t dmem
);

    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_load;
    logic       is_store;

    assign opcode   = ex_in.instr[6:0];
    assign funct3   = ex_in.instr[14:12];
    assign is_load  = (opcode == op_load);
    assign is_store = (opcode == op_store);

    always_comb begin
        ctrl.branch_kind = rv_mem_pkg::br_none;
        ctrl.load_kind   = rv_mem_pkg::ld_none;
        ctrl.rd          = ex_in.instr[11:7];

        if (opcode == op_branch) begin
            case (funct3)
                3'b000:  ctrl.branch_kind = rv_mem_pkg::br_eq;
                3'b001:  ctrl.branch_kind = rv_mem_pkg::br_ne;
                3'b100:  ctrl.branch_kind = rv_mem_pkg::br_lt;
                3'b101:  ctrl.branch_kind = rv_mem_pkg::br_ge;
                3'b110:  ctrl.branch_kind = rv_mem_pkg::br_ltu;
                3'b111:  ctrl.branch_kind = rv_mem_pkg::br_geu;
                default: ctrl.branch_kind = rv_mem_pkg::br_none; // 010 and 011 reserved
            endcase
        end else if (opcode == op_jalr) begin
            ctrl.branch_kind = rv_mem_pkg::br_jalr;
        end

        if (is_load) begin
            case (funct3)
                3'b000:  ctrl.load_kind = rv_mem_pkg::ld_b;
                3'b001:  ctrl.load_kind = rv_mem_pkg::ld_h;
                3'b010:  ctrl.load_kind = rv_mem_pkg::ld_w;
                3'b100:  ctrl.load_kind = rv_mem_pkg::ld_bu;
                3'b101:  ctrl.load_kind = rv_mem_pkg::ld_hu;
                default: ctrl.load_kind = rv_mem_pkg::ld_none;
            endcase
        end
    end

    // Memory is combinational, so the request goes out this cycle
    always_comb begin
        dmem.addr  = ex_in.alu_result;
        dmem.wdata = ex_in.rs2_val;
        dmem.req   = is_load || is_store;
        dmem.write = is_store;

        // Unsigned loads share the size of their signed partner
        case (funct3[1:0])
            2'b00:   dmem.size = `RV_SIZE_BYTE;
            2'b01:   dmem.size = `RV_SIZE_HALF;
            default: dmem.size = `RV_SIZE_WORD;
        endcase
    end

endmodule

// ==== hdl/mem_wb_reg.sv ====
`timescale 1ns/1ps
`include "rv_mem_config.svh"

module mem_wb_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  keep,   // Stall holds the register
    input  logic                  nop,    // Insert a bubble
    input  rv_mem_pkg::ex_mem_t   ex_in,
    input  rv_mem_pkg::mem_ctrl_t ctrl,
    input  logic [`RV_XLEN-1:0]   rdata,
    output rv_mem_pkg::mem_wb_t   wb
);

    logic [`RV_XLEN-1:0] load_ext;
    rv_mem_pkg::mem_wb_t wb_next;

    // Data always sits in the low lanes of rdata
    always_comb begin
        case (ctrl.load_kind)
            rv_mem_pkg::ld_b: begin
                load_ext = {{(`RV_XLEN-8){rdata[7]}}, rdata[7:0]};
            end
            rv_mem_pkg::ld_h: begin
                load_ext = {{(`RV_XLEN-16){rdata[15]}}, rdata[15:0]};
            end
            rv_mem_pkg::ld_w: begin
                load_ext = rdata;
            end
            rv_mem_pkg::ld_bu: begin
                load_ext = {{(`RV_XLEN-8){1'b0}}, rdata[7:0]};
            end
            rv_mem_pkg::ld_hu: begin
                load_ext = {{(`RV_XLEN-16){1'b0}}, rdata[15:0]};
            end
            default: begin
                load_ext = '0;   // Not a load
            end
        endcase
    end

    always_comb begin
        wb_next.reg_write  = ex_in.reg_write;
        wb_next.wb_sel     = ex_in.wb_sel;
        wb_next.rd         = ctrl.rd;
        wb_next.alu_result = ex_in.alu_result;
        wb_next.pc_plus4   = ex_in.pc_plus4;
        wb_next.load_data  = load_ext;
        wb_next.instr      = ex_in.instr;
        wb_next.fwd_tag    = ex_in.fwd_tag;
    end

    // Priority is reset, then keep, then nop, then capture
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb <= '0;
        end else if (!keep) begin
            if (nop) begin
                wb <= '0;        // Bubble with reg_write low
            end else begin
                wb <= wb_next;
            end
        end
    end

endmodule

// ==== hdl/rv_mem_config.svh ====
`ifndef RV_MEM_CONFIG_SVH
`define RV_MEM_CONFIG_SVH

// Datapath and address width
`define RV_XLEN 32

// Architectural register index width
`define RV_REG_IDX_W 5

// Data-memory access size codes
`define RV_SIZE_BYTE 2'd0
`define RV_SIZE_HALF 2'd1
`define RV_SIZE_WORD 2'd2

`endif

// ==== hdl/rv_mem_pkg.sv ====
`include "rv_mem_config.svh"

package rv_mem_pkg;

    // Codes follow the execute-stage branch field
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_eq   = 3'd1,
        br_ne   = 3'd2,
        br_lt   = 3'd3,
        br_ge   = 3'd4,
        br_ltu  = 3'd5,
        br_geu  = 3'd6,
        br_jalr = 3'd7
    } branch_kind_e;

    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_b    = 3'd1,
        ld_h    = 3'd2,
        ld_w    = 3'd3,
        ld_bu   = 3'd4,
        ld_hu   = 3'd5
    } load_kind_e;

    // Bundle handed over by execute
    typedef struct packed {
        logic [31:0]         instr;
        logic [`RV_XLEN-1:0] pc_plus4;
        logic [`RV_XLEN-1:0] branch_target;
        logic [`RV_XLEN-1:0] alu_result;     // Also the memory address
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;        // Store data
        logic                reg_write;
        logic [1:0]          wb_sel;
        logic [1:0]          fwd_tag;        // Load-use forwarding marker
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic [1:0]          size;
        logic                req;
        logic                write;
    } dmem_req_t;

    typedef struct packed {
        branch_kind_e             branch_kind;
        load_kind_e               load_kind;
        logic [`RV_REG_IDX_W-1:0] rd;
    } mem_ctrl_t;

    // Contents of the writeback pipeline register
    typedef struct packed {
        logic                     reg_write;
        logic [1:0]               wb_sel;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [`RV_XLEN-1:0]      alu_result;
        logic [`RV_XLEN-1:0]      pc_plus4;
        logic [`RV_XLEN-1:0]      load_data;
        logic [31:0]              instr;
        logic [1:0]               fwd_tag;
    } mem_wb_t;

endpackage

// ==== verification/tb_mem_access_stage.sv ====
`timescale 1ns/1ps
`include "rv_mem_config.svh"

module tb_mem_access_stage;

    localparam int num_cycles = 2000;
    localparam int rst_cycles = 16;
    localparam int clk_period = 4;

    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    logic                  clk;
    logic                  rst;
    logic                  keep;
    logic                  nop;
    rv_mem_pkg::ex_mem_t   ex_in;
    rv_mem_pkg::dmem_req_t dmem;
    logic [`RV_XLEN-1:0]   rdata;
    logic [`RV_XLEN-1:0]   redirect_pc;
    logic                  redirect;
    rv_mem_pkg::mem_wb_t   wb;

    logic [`RV_XLEN-1:0]   mem [0:255];   // Word-addressed data memory
    rv_mem_pkg::mem_wb_t   exp_wb;        // Model of the writeback register
    integer                seed;

    mem_access_stage dut (
        .clk         (clk),
        .rst         (rst),
        .keep        (keep),
        .nop         (nop),
        .ex_in       (ex_in),
        .dmem        (dmem),
        .rdata       (rdata),
        .redirect_pc (redirect_pc),
        .redirect    (redirect),
        .wb          (wb)
    );

    assign rdata = mem[dmem.addr[9:2]];   // No wait states

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((rst_cycles + num_cycles + 100) * clk_period);
        $display("Timeout: the run did not finish within the expected time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    task automatic check_equal(input logic [255:0] actual, input logic [255:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [1:0] size_of(input logic [2:0] funct3);
        case (funct3)
            3'b000, 3'b100: size_of = `RV_SIZE_BYTE;
            3'b001, 3'b101: size_of = `RV_SIZE_HALF;
            default:        size_of = `RV_SIZE_WORD;
        endcase
    endfunction

    function automatic logic [31:0] extend_load(input logic [2:0] funct3,
                                                input logic [31:0] word);
        case (funct3)
            3'b000:  extend_load = {{24{word[7]}}, word[7:0]};    // LB
            3'b001:  extend_load = {{16{word[15]}}, word[15:0]};  // LH
            3'b010:  extend_load = word;                          // LW
            3'b100:  extend_load = {24'h0, word[7:0]};            // LBU
            3'b101:  extend_load = {16'h0, word[15:0]};           // LHU
            default: extend_load = 32'h0;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [31:0] instr, input logic [31:0] a,
                                          input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        branch_taken = 1'b0;
        if (instr[6:0] == op_jalr) begin
            branch_taken = 1'b1;
        end else if (instr[6:0] == op_branch) begin
            case (instr[14:12])
                3'b000:  branch_taken = (a == b);
                3'b001:  branch_taken = (a != b);
                3'b100:  branch_taken = (sa < sb);
                3'b101:  branch_taken = (sa >= sb);
                3'b110:  branch_taken = (a < b);
                3'b111:  branch_taken = (a >= b);
                default: branch_taken = 1'b0;
            endcase
        end
    endfunction

    // Runs mid-cycle once inputs and outputs have settled
    task automatic check_cycle();
        logic [6:0]  opcode;
        logic        is_load;
        logic        is_store;
        logic [31:0] exp_pc;
        opcode   = ex_in.instr[6:0];
        is_load  = (opcode == op_load);
        is_store = (opcode == op_store);
        exp_pc   = (opcode == op_jalr) ? ex_in.alu_result : ex_in.branch_target;

        check_equal(dmem.req, is_load || is_store, "dmem.req");
        check_equal(dmem.write, is_store, "dmem.write");
        check_equal(dmem.addr, ex_in.alu_result, "dmem.addr");
        check_equal(dmem.wdata, ex_in.rs2_val, "dmem.wdata");
        check_equal(dmem.size, size_of(ex_in.instr[14:12]), "dmem.size");
        check_equal(redirect, branch_taken(ex_in.instr, ex_in.rs1_val, ex_in.rs2_val),
                    "redirect");
        if (redirect) begin
            check_equal(redirect_pc, exp_pc, "redirect_pc");
        end

        check_equal(wb.load_data, exp_wb.load_data, "wb.load_data");
        check_equal(wb, exp_wb, "wb");

        // Value the register should take at the coming edge
        if (!rst || (!keep && nop)) begin
            exp_wb = '0;
        end else if (!keep) begin
            exp_wb.reg_write  = ex_in.reg_write;
            exp_wb.wb_sel     = ex_in.wb_sel;
            exp_wb.rd         = ex_in.instr[11:7];
            exp_wb.alu_result = ex_in.alu_result;
            exp_wb.pc_plus4   = ex_in.pc_plus4;
            exp_wb.load_data  = is_load ?
                extend_load(ex_in.instr[14:12], mem[ex_in.alu_result[9:2]]) : 32'h0;
            exp_wb.instr      = ex_in.instr;
            exp_wb.fwd_tag    = ex_in.fwd_tag;
        end
    endtask

    always @(negedge clk) begin
        check_cycle();
    end

    task automatic drive_item();
        logic                keep_next;
        logic [2:0]          kind;
        logic [6:0]          opcode;
        rv_mem_pkg::ex_mem_t item;
        keep_next = (({$random(seed)} % 10) == 0);
        keep <= keep_next;
        nop  <= (({$random(seed)} % 10) == 0);
        if (!keep_next) begin   // Upstream holds ex_in during a stall
            kind = {$random(seed)} % 5;
            case (kind)
                3'd0:    opcode = op_load;
                3'd1:    opcode = op_store;
                3'd2:    opcode = op_branch;
                3'd3:    opcode = op_jalr;
                default: opcode = $random(seed);
            endcase
            item.instr         = $random(seed);   // Random funct3, rd and immediates
            item.instr[6:0]    = opcode;
            item.pc_plus4      = $random(seed);
            item.branch_target = $random(seed);
            item.alu_result    = $random(seed);
            item.rs1_val       = $random(seed);
            item.rs2_val       = (({$random(seed)} % 4) == 0) ? item.rs1_val : $random(seed);
            item.reg_write     = $random(seed);
            item.wb_sel        = $random(seed);
            item.fwd_tag       = $random(seed);
            ex_in <= item;
        end
    endtask

    initial begin
        seed      = 89125;
        exp_wb    = '0;
        rst       = 1'b0;
        keep      = 1'b0;
        nop       = 1'b0;
        ex_in     = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = $random(seed) ^ {4{i[7:0]}};
        end

        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b1;
        repeat (num_cycles) begin
            @(posedge clk);
            drive_item();
        end
        repeat (2) @(posedge clk);   // Let the last item reach wb and be checked

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/rv_mem_pkg.sv
hdl/mem_op_decode.sv
hdl/branch_resolve.sv
hdl/mem_wb_reg.sv
hdl/mem_access_stage.sv
verification/tb_mem_access_stage.sv
